/* hw/color_mapper.sv */
`timescale 1ns/1ps
`include "julia_macros.svh"

module color_mapper import julia_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        color_load,
   input  iter_cnt_t   count,
   output logic [31:0] color
);

   logic [31:0] palette;
   logic [7:0]  grad_mid;
   logic [7:0]  grad_low;

   always_comb begin
      // Doubling wraps at 256
      grad_mid = {count[6:0], 1'b0};
      grad_low = 8'hFF - count;
      if (count == iter_cnt_t'(`JULIA_MAX_ITER)) begin
         // Interior of the set
         palette = 32'h0000_0000;
      end else begin
         palette = {8'hFF, count, grad_mid, grad_low};
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         color <= '0;
      end else if (color_load) begin
         color <= palette;
      end
   end

endmodule

/* hw/escape_iterator.sv */
`timescale 1ns/1ps
`include "julia_macros.svh"

module escape_iterator import julia_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   julia_if.iterator bus
);

   localparam int W = `JULIA_WIDTH;

   // Working copy of z and c
   fix_t zr;
   fix_t zi;
   fix_t cr;
   fix_t ci;

   logic running;

   // Full-width products
   logic signed [2*W-1:0] rr;
   logic signed [2*W-1:0] ii;
   logic signed [2*W-1:0] ri;

   logic signed [2*W:0]   mag2;
   logic signed [2*W:0]   diff;
   logic signed [2*W:0]   twice;
   logic signed [2*W:0]   sh_re;
   logic signed [2*W:0]   sh_im;

   fix_t next_re;
   fix_t next_im;
   logic escaped;
   logic at_limit;

   always_comb begin
      rr = zr * zr;
      ii = zi * zi;
      ri = zr * zi;

      mag2  = rr + ii;
      diff  = rr - ii;
      twice = ri <<< 1;

      // Back to Q11.11 with wrap on overflow
      sh_re = diff >>> `JULIA_FRAC;
      sh_im = twice >>> `JULIA_FRAC;
      next_re = sh_re[W-1:0] + cr;
      next_im = sh_im[W-1:0] + ci;

      escaped  = mag2 > `JULIA_ESCAPE;
      at_limit = bus.count == iter_cnt_t'(`JULIA_MAX_ITER);
   end

   // Data path
   always_ff @(posedge clk) begin
      if (bus.map_valid) begin
         zr        <= bus.z_re;
         zi        <= bus.z_im;
         cr        <= bus.c_re;
         ci        <= bus.c_im;
         bus.count <= '0;
      end else if (running && !escaped && !at_limit) begin
         zr        <= next_re;
         zi        <= next_im;
         bus.count <= bus.count + 1'b1;
      end
   end

   // One escape test per cycle while running
   always_ff @(posedge clk) begin
      if (rst) begin
         running       <= 1'b0;
         bus.iter_done <= 1'b0;
      end else begin
         bus.iter_done <= 1'b0;
         if (bus.map_valid) begin
            running <= 1'b1;
         end else if (running && (escaped || at_limit)) begin
            running       <= 1'b0;
            bus.iter_done <= 1'b1;
         end
      end
   end

endmodule

/* hw/julia_if.sv */
`timescale 1ns/1ps

interface julia_if import julia_pkg::*; ();

   // Mapper to iterator
   logic      map_valid;
   fix_t      z_re;
   fix_t      z_im;
   fix_t      c_re;
   fix_t      c_im;

   // Iterator results
   logic      iter_done;
   iter_cnt_t count;

   modport mapper (
      output map_valid,
      output z_re,
      output z_im,
      output c_re,
      output c_im
   );

   modport iterator (
      input  map_valid,
      input  z_re,
      input  z_im,
      input  c_re,
      input  c_im,
      output iter_done,
      output count
   );

   modport ctrl (
      input  iter_done
   );

endinterface

/* hw/julia_macros.svh */
`ifndef JULIA_MACROS_SVH
`define JULIA_MACROS_SVH

// Fixed-point format Q11.11
`define JULIA_WIDTH        22
`define JULIA_FRAC         11

// Iteration limit and count width
`define JULIA_MAX_ITER     255
`define JULIA_CNT_BITS     8

// Screen geometry
`define JULIA_COORD_BITS   10
`define JULIA_X_CENTER     320
`define JULIA_Y_CENTER     240
`define JULIA_SCREEN_W     640

// One pixel step is 1/256 on the complex plane
`define JULIA_SCALE_SHIFT  3

// Frame buffer base in SDRAM
`define JULIA_ADDR_OFFSET  32'h0800_0000

// Escape bound 4.0 on |z|^2, which carries twice the fraction bits
`define JULIA_ESCAPE       (4 << (2 * `JULIA_FRAC))

`endif

/* hw/julia_pkg.sv */
`include "julia_macros.svh"

package julia_pkg;

   // Signed fixed-point word
   typedef logic signed [`JULIA_WIDTH-1:0] fix_t;

   // Screen column or row
   typedef logic [`JULIA_COORD_BITS-1:0] coord_t;

   // Escape iteration count
   typedef logic [`JULIA_CNT_BITS-1:0] iter_cnt_t;

   // Worker controller states
   typedef enum logic [1:0] {
      IDLE,
      MAP,
      ITER,
      WRITE
   } ctrl_state_e;

endpackage

/* hw/julia_worker.sv */
`timescale 1ns/1ps

module julia_worker import julia_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  coord_t      x,
   input  coord_t      y,
   input  logic        start,
   input  logic        mem_busy,
   input  fix_t        c_re,
   input  fix_t        c_im,
   output logic        ready,
   output logic        done,
   output logic [31:0] color,
   output logic [31:0] address
);

   logic map_en;
   logic color_load;

   julia_if jif ();

   worker_ctrl worker_ctrl_i (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .mem_busy   (mem_busy),
      .bus        (jif.ctrl),
      .map_en     (map_en),
      .color_load (color_load),
      .ready      (ready),
      .done       (done)
   );

   pixel_mapper pixel_mapper_i (
      .clk     (clk),
      .rst     (rst),
      .map_en  (map_en),
      .x       (x),
      .y       (y),
      .c_re    (c_re),
      .c_im    (c_im),
      .bus     (jif.mapper),
      .address (address)
   );

   escape_iterator escape_iterator_i (
      .clk (clk),
      .rst (rst),
      .bus (jif.iterator)
   );

   // Count is stable from iter_done until the next map
   color_mapper color_mapper_i (
      .clk        (clk),
      .rst        (rst),
      .color_load (color_load),
      .count      (jif.count),
      .color      (color)
   );

endmodule

/* hw/pixel_mapper.sv */
`timescale 1ns/1ps
`include "julia_macros.svh"

module pixel_mapper import julia_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        map_en,
   input  coord_t      x,
   input  coord_t      y,
   input  fix_t        c_re,
   input  fix_t        c_im,
   julia_if.mapper     bus,
   output logic [31:0] address
);

   fix_t        dx;
   fix_t        dy;
   logic [31:0] pix_index;

   // Offsets from screen centre with the imaginary axis pointing up
   always_comb begin
      dx = fix_t'(x) - fix_t'(`JULIA_X_CENTER);
      dy = fix_t'(`JULIA_Y_CENTER) - fix_t'(y);
      pix_index = 32'(y) * `JULIA_SCREEN_W + 32'(x);
   end

   // Start point and constant
   always_ff @(posedge clk) begin
      if (map_en) begin
         bus.z_re <= dx <<< `JULIA_SCALE_SHIFT;
         bus.z_im <= dy <<< `JULIA_SCALE_SHIFT;
         bus.c_re <= c_re;
         bus.c_im <= c_im;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         bus.map_valid <= 1'b0;
         address       <= '0;
      end else begin
         bus.map_valid <= map_en;
         // Four bytes per pixel
         if (map_en) begin
            address <= `JULIA_ADDR_OFFSET + (pix_index << 2);
         end
      end
   end

endmodule

/* hw/worker_ctrl.sv */
`timescale 1ns/1ps

module worker_ctrl import julia_pkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  logic  start,
   input  logic  mem_busy,
   julia_if.ctrl bus,
   output logic  map_en,
   output logic  color_load,
   output logic  ready,
   output logic  done
);

   ctrl_state_e state;
   ctrl_state_e state_nxt;

   always_comb begin
      ready      = state == IDLE;
      map_en     = ready && start;
      color_load = (state == WRITE) && !mem_busy;
   end

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (start) begin
               state_nxt = MAP;
            end
         end
         // Mapper output is valid now
         MAP: state_nxt = ITER;
         ITER: begin
            if (bus.iter_done) begin
               state_nxt = WRITE;
            end
         end
         // Hold here while memory is busy
         WRITE: begin
            if (!mem_busy) begin
               state_nxt = IDLE;
            end
         end
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IDLE;
         done  <= 1'b0;
      end else begin
         state <= state_nxt;
         // Lines up with the registered color
         done  <= color_load;
      end
   end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f \
   --top-module julia_worker_tb -Mdir obj_dir -o julia_sim

./obj_dir/julia_sim | tee sim.log

if grep -q "Verification failed" sim.log; then
   echo "Simulation reported failure"
   exit 1
fi
echo "Simulation finished without failure"

/* tb/julia_worker_tb.sv */
`timescale 1ns/1ps
`include "julia_macros.svh"

module julia_worker_tb import julia_pkg::*; ();

   localparam int N_RANDOM  = 40;
   localparam int CLK_NS    = 10;
   localparam int JOB_LIMIT = `JULIA_MAX_ITER + 20;
   localparam int ONE       = 1 << `JULIA_FRAC;

   logic        clk;
   logic        rst;
   coord_t      x;
   coord_t      y;
   logic        start;
   logic        mem_busy;
   fix_t        c_re;
   fix_t        c_im;
   logic        ready;
   logic        done;
   logic [31:0] color;
   logic [31:0] address;

   int          errors;
   int          accepted;
   int          done_seen = 0;
   logic [31:0] last_color;

   julia_worker julia_worker_i (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   // Worst case every job runs to the iteration limit
   initial begin
      #((N_RANDOM + 10) * JOB_LIMIT * CLK_NS);
      $display("Run timed out before all jobs completed");
      $display("Verification failed");
      $finish;
   end

   always @(negedge clk) begin
      if (!rst && done) begin
         done_seen++;
      end
   end

   task automatic check_color(string name, logic [31:0] exp, logic [31:0] act);
      if (act !== exp) begin
         $display("mismatch %s color expected %08h actual %08h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_address(string name, logic [31:0] exp, logic [31:0] act);
      if (act !== exp) begin
         $display("mismatch %s address expected %08h actual %08h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_count_flag(string name, logic exp, logic act);
      if (act !== exp) begin
         $display("mismatch %s expected %b actual %b", name, exp, act);
         errors++;
      end
   endtask

   // Escape count from the fixed-point rules
   function automatic iter_cnt_t model_count(coord_t px, coord_t py, fix_t cr, fix_t ci);
      fix_t   zr;
      fix_t   zi;
      fix_t   tr;
      longint rr;
      longint ii;
      longint ri;
      int     n;
      zr = fix_t'((int'(px) - `JULIA_X_CENTER) * (1 << `JULIA_SCALE_SHIFT));
      zi = fix_t'((`JULIA_Y_CENTER - int'(py)) * (1 << `JULIA_SCALE_SHIFT));
      n = 0;
      while (n < `JULIA_MAX_ITER) begin
         rr = longint'(zr) * longint'(zr);
         ii = longint'(zi) * longint'(zi);
         ri = longint'(zr) * longint'(zi);
         if (rr + ii > longint'(`JULIA_ESCAPE)) begin
            break;
         end
         tr = fix_t'((rr - ii) >>> `JULIA_FRAC) + cr;
         zi = fix_t'((2 * ri) >>> `JULIA_FRAC) + ci;
         zr = tr;
         n++;
      end
      return iter_cnt_t'(n);
   endfunction

   function automatic logic [31:0] model_color(iter_cnt_t n);
      if (n == iter_cnt_t'(`JULIA_MAX_ITER)) begin
         return 32'h0000_0000;
      end
      return {8'hFF, n, 8'((2 * int'(n)) % 256), 8'(255 - int'(n))};
   endfunction

   // One pixel job with memory busy for the first busy_extra cycles of WRITE
   task automatic run_job(string name, coord_t jx, coord_t jy, fix_t jcr, fix_t jci,
                          int busy_extra, logic poke);
      iter_cnt_t   n_exp;
      logic [31:0] exp_color;
      logic [31:0] exp_addr;
      int          hold;
      int          n;
      n_exp     = model_count(jx, jy, jcr, jci);
      exp_color = model_color(n_exp);
      exp_addr  = `JULIA_ADDR_OFFSET + 32'(4 * (int'(jy) * `JULIA_SCREEN_W + int'(jx)));
      hold      = int'(n_exp) + 4 + busy_extra;
      x     = jx;
      y     = jy;
      c_re  = jcr;
      c_im  = jci;
      start = 1'b1;
      accepted++;
      n = 0;
      while (n <= hold + JOB_LIMIT) begin
         @(posedge clk);
         #1;
         n++;
         start = 1'b0;
         if (done && mem_busy) begin
            $display("%s: done arrived while memory was busy", name);
            errors++;
         end
         if (done) begin
            break;
         end
         check_count_flag({name, " ready"}, 1'b0, ready);
         check_color({name, " hold"}, last_color, color);
         // A start with another x while busy must be dropped
         if (poke && n == 2) begin
            x     = jx + 10'd1;
            start = 1'b1;
         end
         mem_busy = n < hold;
      end
      if (!done) begin
         $display("%s: no done pulse within %0d cycles", name, n);
         errors++;
      end
      check_color(name, exp_color, color);
      check_address(name, exp_addr, address);
      check_count_flag({name, " ready at done"}, 1'b1, ready);
      last_color = exp_color;
      mem_busy   = 1'b0;
   endtask

   initial begin
      fix_t rcr;
      fix_t rci;
      void'($urandom(32'hefed0fa6));
      rst        = 1'b1;
      start      = 1'b0;
      mem_busy   = 1'b0;
      x          = '0;
      y          = '0;
      c_re       = '0;
      c_im       = '0;
      errors     = 0;
      accepted   = 0;
      last_color = '0;
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;

      check_count_flag("reset ready", 1'b1, ready);
      check_count_flag("reset done", 1'b0, done);
      check_color("reset", 32'h0, color);
      check_address("reset", 32'h0, address);

      run_job("centre", 10'd320, 10'd240, '0, '0, 0, 1'b0);
      run_job("corner", 10'd0, 10'd0, fix_t'(ONE), fix_t'(ONE), 2, 1'b0);
      run_job("backpressure", 10'd639, 10'd479, fix_t'(ONE / 2), fix_t'(ONE / 2), 30, 1'b0);
      run_job("ignored start", 10'd100, 10'd50, fix_t'(-ONE / 2), fix_t'(ONE / 4), 1, 1'b1);

      for (int i = 0; i < N_RANDOM; i++) begin
         rcr = fix_t'(int'($urandom_range(2 * ONE)) - ONE);
         rci = fix_t'(int'($urandom_range(2 * ONE)) - ONE);
         run_job($sformatf("random %0d", i), coord_t'($urandom_range(639)),
                 coord_t'($urandom_range(479)), rcr, rci, int'($urandom_range(5)), 1'b0);
      end

      repeat (3) @(posedge clk);
      #1;
      if (done_seen != accepted) begin
         $display("Saw %0d done pulses for %0d accepted starts", done_seen, accepted);
         errors++;
      end
      $display("Errors: %0d, jobs: %0d, done pulses: %0d", errors, accepted, done_seen);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

/* vlog.f */
+incdir+hw
hw/julia_pkg.sv
hw/julia_if.sv
hw/pixel_mapper.sv
hw/escape_iterator.sv
hw/color_mapper.sv
hw/worker_ctrl.sv
hw/julia_worker.sv
tb/julia_worker_tb.sv
